// File: pkt_gen_pkg.sv
/* shared sizes, limits and types of the tx packet generator
   lengths count the 4 crc bytes, which are never put on the bus */
package pkt_gen_pkg;

	// ----------------------------------------
	// bus sizes
	// ----------------------------------------
	localparam int beat_bytes = 64;  // bytes per beat
	localparam int byte_w = 8;
	localparam int data_w = beat_bytes * byte_w;  // 512
	localparam int empty_w = 6;  // unused byte count on eop
	localparam int len_w = 14;  // frame length incl crc
	localparam int cnt_w = 32;  // packets per run
	localparam int idx_w = 16;  // packet index in header
	localparam int mac_w = 48;

	// ----------------------------------------
	// length rules
	// ----------------------------------------
	localparam int crc_bytes = 4;  // counted in length, not sent
	localparam int hdr_overhead = 18;  // da + sa + type/len + crc
	localparam int min_len = 64;
	localparam int max_len = 9600;  // jumbo limit

	// ----------------------------------------
	// header beat layout, msb first
	// ----------------------------------------
	// da[47:0] | sa[47:0] | len-18 [15:0] | index [15:0] | filler
	localparam int len_field_w = 16;
	localparam int hdr_w = 2 * mac_w + len_field_w + idx_w;  // 128 bits

	// beat currently being built
	typedef enum logic [1:0] {
		st_idle = 2'd0,
		st_sop  = 2'd1,
		st_data = 2'd2,
		st_eop  = 2'd3
	} gen_state_t;

	// length sequence
	typedef enum logic {
		mode_fixed = 1'b0,  // every packet start_len
		mode_incr  = 1'b1   // start_len .. end_len, then wrap
	} len_mode_t;

endpackage

// File: pkt_gen_ctrl.sv
/* sequencer for one run of packets; every register holds while ena_i is low
   start is taken only when idle and no run is armed */
`timescale 1ns/1ps

module pkt_gen_ctrl (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    ena_i,           // tx ack level
	input  logic                    start_i,         // raw start pulse
	input  logic                    pkt_num_zero_i,
	input  logic                    last_beat_i,     // current beat ends the packet
	input  logic                    last_pkt_i,      // current packet ends the run
	output pkt_gen_pkg::gen_state_t state_o,
	output logic                    load_o,          // packet start
	output logic                    advance_o,       // step the length sequence
	output logic                    busy_o
);

	pkt_gen_pkg::gen_state_t state_q;  // only idle, sop, data are stored
	logic armed;  // start seen, config being captured
	logic busy_q;
	logic start_ok;
	logic pkt_start;

	// ----------------------------------------
	// decode
	// ----------------------------------------
	assign start_ok = start_i && !busy_q && !armed && !pkt_num_zero_i;

	// first packet one cycle after start, later ones right off the last beat
	always_comb begin
		if (state_q == pkt_gen_pkg::st_idle)
			pkt_start = armed;
		else
			pkt_start = last_beat_i && !last_pkt_i;
	end

	assign load_o = pkt_start;
	assign advance_o = pkt_start;  // next length is ready one cycle later

	// last beat of a multi beat packet is shown as eop
	assign state_o = (state_q == pkt_gen_pkg::st_data && last_beat_i) ?
		pkt_gen_pkg::st_eop : state_q;

	assign busy_o = busy_q;

	// ----------------------------------------
	// state register
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= pkt_gen_pkg::st_idle;
			armed <= 1'b0;
			busy_q <= 1'b0;
		end else if (ena_i) begin
			case (state_q)
				pkt_gen_pkg::st_idle: begin
					if (armed) begin
						state_q <= pkt_gen_pkg::st_sop;
						busy_q <= 1'b1;
						armed <= 1'b0;
					end else begin
						busy_q <= 1'b0;  // one beat after the final eop
						armed <= start_ok;
					end
				end
				pkt_gen_pkg::st_sop,
				pkt_gen_pkg::st_data: begin
					if (!last_beat_i)
						state_q <= pkt_gen_pkg::st_data;
					else if (last_pkt_i)
						state_q <= pkt_gen_pkg::st_idle;  // run done
					else
						state_q <= pkt_gen_pkg::st_sop;  // back to back
				end
				default: state_q <= pkt_gen_pkg::st_idle;
			endcase
		end
	end

endmodule

// File: pkt_run_counter.sv
/* byte, packet and index counters for the current run
   load wins over start, so a start in the same beat as a packet load is lost */
`timescale 1ns/1ps

module pkt_run_counter (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          ena_i,
	input  logic                          start_i,      // honored run start
	input  logic                          load_i,       // packet start
	input  logic [pkt_gen_pkg::len_w-1:0] len_i,        // length incl crc
	input  logic [pkt_gen_pkg::cnt_w-1:0] pkt_num_i,
	output logic                          last_beat_o,
	output logic                          last_pkt_o,
	output logic [pkt_gen_pkg::len_w-1:0] beat_off_o,   // byte offset of beat
	output logic [pkt_gen_pkg::idx_w-1:0] pkt_index_o
);

	logic [pkt_gen_pkg::len_w-1:0] bytes_left;  // incl current beat
	logic [pkt_gen_pkg::cnt_w-1:0] pkts_left;   // after current packet
	logic [pkt_gen_pkg::idx_w-1:0] idx_next;

	assign last_beat_o = bytes_left <= pkt_gen_pkg::len_w'(pkt_gen_pkg::beat_bytes);
	assign last_pkt_o = pkts_left == '0;

	// ----------------------------------------
	// per beat and per packet counts
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			bytes_left <= '0;  // reads as last beat while idle
			beat_off_o <= '0;
			pkts_left <= '0;
			pkt_index_o <= '0;
			idx_next <= '0;
		end else if (ena_i) begin
			if (load_i) begin
				bytes_left <= len_i - pkt_gen_pkg::len_w'(pkt_gen_pkg::crc_bytes);
				beat_off_o <= '0;
				pkts_left <= pkts_left - 1'b1;
				pkt_index_o <= idx_next;  // carries across runs
				idx_next <= idx_next + 1'b1;
			end else begin
				if (start_i)
					pkts_left <= pkt_num_i;
				// hold on the last beat, so idle keeps the flag set
				if (!last_beat_o) begin
					bytes_left <= bytes_left - pkt_gen_pkg::len_w'(pkt_gen_pkg::beat_bytes);
					beat_off_o <= beat_off_o + pkt_gen_pkg::len_w'(pkt_gen_pkg::beat_bytes);
				end
			end
		end
	end

endmodule

// File: frame_length_seq.sv
/* length of the next packet; limits are clamped to 64..9600 at run start
   in incr mode an end below the start gives a constant start length */
`timescale 1ns/1ps

module frame_length_seq (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          ena_i,
	input  logic                          start_i,     // honored run start
	input  pkt_gen_pkg::len_mode_t        len_mode_i,
	input  logic [pkt_gen_pkg::len_w-1:0] start_len_i,
	input  logic [pkt_gen_pkg::len_w-1:0] end_len_i,
	input  logic                          advance_i,
	output logic [pkt_gen_pkg::len_w-1:0] next_len_o
);

	pkt_gen_pkg::len_mode_t mode_q;
	logic [pkt_gen_pkg::len_w-1:0] lo_q;  // clamped start_len
	logic [pkt_gen_pkg::len_w-1:0] hi_q;  // clamped end_len

	function automatic logic [pkt_gen_pkg::len_w-1:0] clamp_len(
		input logic [pkt_gen_pkg::len_w-1:0] len
	);
		if (len < pkt_gen_pkg::len_w'(pkt_gen_pkg::min_len))
			return pkt_gen_pkg::len_w'(pkt_gen_pkg::min_len);
		if (len > pkt_gen_pkg::len_w'(pkt_gen_pkg::max_len))
			return pkt_gen_pkg::len_w'(pkt_gen_pkg::max_len);
		return len;
	endfunction

	// ----------------------------------------
	// sequence
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			mode_q <= pkt_gen_pkg::mode_fixed;
			next_len_o <= pkt_gen_pkg::len_w'(pkt_gen_pkg::min_len);
		end else if (ena_i) begin
			if (advance_i) begin
				if (mode_q == pkt_gen_pkg::mode_incr)
					next_len_o <= (next_len_o >= hi_q) ? lo_q : next_len_o + 1'b1;  // wrap
			end else if (start_i) begin
				mode_q <= len_mode_i;
				next_len_o <= clamp_len(start_len_i);
			end
		end
	end

	// limits, written only at run start
	always_ff @(posedge clk) begin
		if (ena_i && start_i && !advance_i) begin
			lo_q <= clamp_len(start_len_i);
			hi_q <= clamp_len(end_len_i);
		end
	end

endmodule

// File: beat_builder.sv
/* output register stage of the client bus; byte 0 is the msb of tx_data_o
   length and addresses are sampled between packets and frozen inside one */
`timescale 1ns/1ps

module beat_builder (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             ena_i,
	input  pkt_gen_pkg::gen_state_t          state_i,
	input  logic                             last_beat_i,
	input  logic [pkt_gen_pkg::len_w-1:0]    len_i,        // length of the next packet
	input  logic [pkt_gen_pkg::len_w-1:0]    beat_off_i,
	input  logic [pkt_gen_pkg::idx_w-1:0]    pkt_index_i,
	input  logic [pkt_gen_pkg::mac_w-1:0]    dest_addr_i,
	input  logic [pkt_gen_pkg::mac_w-1:0]    src_addr_i,
	output logic [pkt_gen_pkg::data_w-1:0]   tx_data_o,
	output logic                             tx_sop_o,
	output logic                             tx_eop_o,
	output logic                             tx_valid_o,
	output logic [pkt_gen_pkg::empty_w-1:0]  tx_empty_o
);

	logic [pkt_gen_pkg::mac_w-1:0] dest_q;
	logic [pkt_gen_pkg::mac_w-1:0] src_q;
	logic [pkt_gen_pkg::len_w-1:0] cur_len;  // length of the packet on the way
	logic [pkt_gen_pkg::data_w-1:0] beat;
	logic [pkt_gen_pkg::empty_w-1:0] empty_calc;
	logic pkt_last;

	// single beat packets end in sop
	assign pkt_last = (state_i == pkt_gen_pkg::st_eop) ||
		(state_i == pkt_gen_pkg::st_sop && last_beat_i);
	assign empty_calc = pkt_gen_pkg::empty_w'(pkt_gen_pkg::crc_bytes - cur_len);  // (4-L) mod 64

	// ----------------------------------------
	// beat contents
	// ----------------------------------------
	always_comb begin
		logic [pkt_gen_pkg::len_w-1:0] off;
		logic [pkt_gen_pkg::len_field_w-1:0] pay_len;

		for (int j = 0; j < pkt_gen_pkg::beat_bytes; j++) begin
			off = beat_off_i + j[pkt_gen_pkg::len_w-1:0];  // packet byte offset
			beat[pkt_gen_pkg::data_w-1-pkt_gen_pkg::byte_w*j -: pkt_gen_pkg::byte_w] =
				off[pkt_gen_pkg::byte_w-1:0];
		end
		pay_len = pkt_gen_pkg::len_field_w'(cur_len - pkt_gen_pkg::hdr_overhead);
		if (state_i == pkt_gen_pkg::st_sop)
			beat[pkt_gen_pkg::data_w-1 -: pkt_gen_pkg::hdr_w] = {dest_q, src_q, pay_len, pkt_index_i};
	end

	// sampled at packet boundaries, so the old length still serves the last beat
	always_ff @(posedge clk) begin
		if (ena_i && (state_i == pkt_gen_pkg::st_idle || pkt_last))
			cur_len <= len_i;
		if (ena_i && state_i == pkt_gen_pkg::st_idle) begin  // frozen during a run
			dest_q <= dest_addr_i;
			src_q <= src_addr_i;
		end
	end

	// ----------------------------------------
	// output registers
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			tx_valid_o <= 1'b0;
			tx_sop_o <= 1'b0;
			tx_eop_o <= 1'b0;
			tx_empty_o <= '0;
		end else if (ena_i) begin
			tx_valid_o <= state_i != pkt_gen_pkg::st_idle;
			tx_sop_o <= state_i == pkt_gen_pkg::st_sop;
			tx_eop_o <= pkt_last;
			tx_empty_o <= pkt_last ? empty_calc : '0;
		end
	end

	always_ff @(posedge clk) begin
		if (ena_i)
			tx_data_o <= beat;
	end

endmodule

// File: pkt_gen_tx.sv
/* tx packet generator for a 512 bit client bus; tx_ack_i stalls everything
   first beat comes 2 acked cycles after start, runs need pkt_num_i > 0 */
`timescale 1ns/1ps

module pkt_gen_tx (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             start_i,
	input  pkt_gen_pkg::len_mode_t           len_mode_i,
	input  logic [pkt_gen_pkg::len_w-1:0]    start_len_i,
	input  logic [pkt_gen_pkg::len_w-1:0]    end_len_i,
	input  logic [pkt_gen_pkg::cnt_w-1:0]    pkt_num_i,
	input  logic [pkt_gen_pkg::mac_w-1:0]    dest_addr_i,
	input  logic [pkt_gen_pkg::mac_w-1:0]    src_addr_i,
	input  logic                             tx_ack_i,     // enable level
	output logic [pkt_gen_pkg::data_w-1:0]   tx_data_o,
	output logic                             tx_sop_o,
	output logic                             tx_eop_o,
	output logic                             tx_valid_o,
	output logic [pkt_gen_pkg::empty_w-1:0]  tx_empty_o,
	output logic                             busy_o
);

	pkt_gen_pkg::gen_state_t state;
	logic pkt_num_zero;
	logic run_start;  // config capture
	logic load;
	logic advance;
	logic last_beat;
	logic last_pkt;
	logic [pkt_gen_pkg::len_w-1:0] next_len;
	logic [pkt_gen_pkg::len_w-1:0] beat_off;
	logic [pkt_gen_pkg::idx_w-1:0] pkt_index;

	assign pkt_num_zero = pkt_num_i == '0;
	assign run_start = start_i && !busy_o && !pkt_num_zero;

	// ----------------------------------------
	pkt_gen_ctrl u_ctrl (
		.clk(clk), .reset(reset), .ena_i(tx_ack_i),
		.start_i(start_i), .pkt_num_zero_i(pkt_num_zero),
		.last_beat_i(last_beat), .last_pkt_i(last_pkt),
		.state_o(state), .load_o(load), .advance_o(advance), .busy_o(busy_o)
	);

	pkt_run_counter u_cnt (
		.clk(clk), .reset(reset), .ena_i(tx_ack_i),
		.start_i(run_start), .load_i(load), .len_i(next_len), .pkt_num_i(pkt_num_i),
		.last_beat_o(last_beat), .last_pkt_o(last_pkt),
		.beat_off_o(beat_off), .pkt_index_o(pkt_index)
	);

	frame_length_seq u_len (
		.clk(clk), .reset(reset), .ena_i(tx_ack_i),
		.start_i(run_start), .len_mode_i(len_mode_i),
		.start_len_i(start_len_i), .end_len_i(end_len_i),
		.advance_i(advance), .next_len_o(next_len)
	);

	beat_builder u_beat (
		.clk(clk), .reset(reset), .ena_i(tx_ack_i),
		.state_i(state), .last_beat_i(last_beat), .len_i(next_len),
		.beat_off_i(beat_off), .pkt_index_i(pkt_index),
		.dest_addr_i(dest_addr_i), .src_addr_i(src_addr_i),
		.tx_data_o(tx_data_o), .tx_sop_o(tx_sop_o), .tx_eop_o(tx_eop_o),
		.tx_valid_o(tx_valid_o), .tx_empty_o(tx_empty_o)
	);

endmodule

// File: pkt_gen_tx_checker.sv
/* bus protocol assertions for pkt_gen_tx, attached with bind
   assertions are quiet during reset */
`timescale 1ns/1ps

module pkt_gen_tx_checker (
	input logic                            clk,
	input logic                            reset,
	input logic                            tx_ack_i,
	input logic [pkt_gen_pkg::data_w-1:0]  tx_data_o,
	input logic                            tx_sop_o,
	input logic                            tx_eop_o,
	input logic                            tx_valid_o,
	input logic [pkt_gen_pkg::empty_w-1:0] tx_empty_o,
	input logic                            busy_o
);

	logic in_pkt;  // sop transferred, eop not yet

	always_ff @(posedge clk) begin
		if (reset)
			in_pkt <= 1'b0;
		else if (tx_valid_o && tx_ack_i) begin
			if (tx_eop_o)
				in_pkt <= 1'b0;
			else if (tx_sop_o)
				in_pkt <= 1'b1;
		end
	end

	// ----------------------------------------
	// protocol
	// ----------------------------------------
	a_hold_on_stall: assert property (@(posedge clk) disable iff (reset)
		!tx_ack_i |=> $stable(tx_data_o) && $stable(tx_valid_o) &&
			$stable(tx_sop_o) && $stable(tx_eop_o) && $stable(tx_empty_o) && $stable(busy_o))
		else $error("outputs moved on a stalled edge");

	a_flags_need_valid: assert property (@(posedge clk) disable iff (reset)
		(tx_sop_o || tx_eop_o) |-> tx_valid_o)
		else $error("sop or eop without valid");

	a_no_nested_sop: assert property (@(posedge clk) disable iff (reset)
		tx_valid_o && tx_sop_o |-> !in_pkt)
		else $error("sop inside an open packet");

	a_empty_only_eop: assert property (@(posedge clk) disable iff (reset)
		!tx_eop_o |-> tx_empty_o == '0)
		else $error("nonzero empty without eop");

endmodule

bind pkt_gen_tx pkt_gen_tx_checker u_chk (
	.clk(clk), .reset(reset), .tx_ack_i(tx_ack_i),
	.tx_data_o(tx_data_o), .tx_sop_o(tx_sop_o), .tx_eop_o(tx_eop_o),
	.tx_valid_o(tx_valid_o), .tx_empty_o(tx_empty_o), .busy_o(busy_o)
);

// File: tb_pkt_gen_tx.sv
/* testbench for pkt_gen_tx; runs come from pkt_gen_testdata.txt in the project root
   transferred beats are compared against a stall free model of the packet stream */
`timescale 1ns/1ps

module tb_pkt_gen_tx;

	localparam int wait_limit = 100000;  // cycles per wait loop

	logic clk;
	logic reset;
	logic start_i;
	pkt_gen_pkg::len_mode_t len_mode_i;
	logic [pkt_gen_pkg::len_w-1:0] start_len_i;
	logic [pkt_gen_pkg::len_w-1:0] end_len_i;
	logic [pkt_gen_pkg::cnt_w-1:0] pkt_num_i;
	logic [pkt_gen_pkg::mac_w-1:0] dest_addr_i;
	logic [pkt_gen_pkg::mac_w-1:0] src_addr_i;
	logic tx_ack_i;
	logic [pkt_gen_pkg::data_w-1:0] tx_data_o;
	logic tx_sop_o;
	logic tx_eop_o;
	logic tx_valid_o;
	logic [pkt_gen_pkg::empty_w-1:0] tx_empty_o;
	logic busy_o;

	int stall_pct;  // ack low chance in percent
	logic [pkt_gen_pkg::idx_w-1:0] exp_index;  // carries across runs

	// transferred beats
	logic [pkt_gen_pkg::data_w-1:0] got_data[$];
	logic got_sop[$];
	logic got_eop[$];
	logic [pkt_gen_pkg::empty_w-1:0] got_empty[$];
	// model beats
	logic [pkt_gen_pkg::data_w-1:0] exp_data[$];
	logic exp_sop[$];
	logic exp_eop[$];
	logic [pkt_gen_pkg::empty_w-1:0] exp_empty[$];

	pkt_gen_tx uut (
		.clk(clk), .reset(reset), .start_i(start_i), .len_mode_i(len_mode_i),
		.start_len_i(start_len_i), .end_len_i(end_len_i), .pkt_num_i(pkt_num_i),
		.dest_addr_i(dest_addr_i), .src_addr_i(src_addr_i), .tx_ack_i(tx_ack_i),
		.tx_data_o(tx_data_o), .tx_sop_o(tx_sop_o), .tx_eop_o(tx_eop_o),
		.tx_valid_o(tx_valid_o), .tx_empty_o(tx_empty_o), .busy_o(busy_o)
	);

	always #5 clk = ~clk;  // 10 ns

	// every acked valid beat is a transfer
	always @(posedge clk) begin
		if (!reset && tx_valid_o && tx_ack_i) begin
			got_data.push_back(tx_data_o);
			got_sop.push_back(tx_sop_o);
			got_eop.push_back(tx_eop_o);
			got_empty.push_back(tx_empty_o);
		end
	end

	// ----------------------------------------
	// compare tasks
	// ----------------------------------------
	task automatic stop_on_error();
		$display("Verification failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic compare_data(input string name, input logic [pkt_gen_pkg::data_w-1:0] got,
		input logic [pkt_gen_pkg::data_w-1:0] exp);
		if (got !== exp) begin
			$display("FAILED time=%0t %s got=%h exp=%h", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic compare_empty(input string name, input logic [pkt_gen_pkg::empty_w-1:0] got,
		input logic [pkt_gen_pkg::empty_w-1:0] exp);
		if (got !== exp) begin
			$display("FAILED time=%0t %s got=%0d exp=%0d", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic compare_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED time=%0t %s got=%b exp=%b", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic compare_count(input string name, input logic [pkt_gen_pkg::cnt_w-1:0] got,
		input logic [pkt_gen_pkg::cnt_w-1:0] exp);
		if (got !== exp) begin
			$display("FAILED time=%0t %s got=%0d exp=%0d", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	// ----------------------------------------
	// model
	// ----------------------------------------
	function automatic int clamp_length(input int len);
		if (len < pkt_gen_pkg::min_len)
			return pkt_gen_pkg::min_len;
		if (len > pkt_gen_pkg::max_len)
			return pkt_gen_pkg::max_len;
		return len;
	endfunction

	task automatic build_expected(input int mode, input int sl, input int el, input int n,
		input logic [pkt_gen_pkg::mac_w-1:0] da, input logic [pkt_gen_pkg::mac_w-1:0] sa);
		int lo;
		int hi;
		int len;
		int nbytes;
		int beats;
		int off;
		logic [pkt_gen_pkg::data_w-1:0] beat;
		logic [15:0] pay_len;

		lo = clamp_length(sl);
		hi = clamp_length(el);
		len = lo;
		for (int p = 0; p < n; p++) begin
			nbytes = len - pkt_gen_pkg::crc_bytes;  // crc not on the bus
			beats = (nbytes + pkt_gen_pkg::beat_bytes - 1) / pkt_gen_pkg::beat_bytes;
			pay_len = 16'(len - pkt_gen_pkg::hdr_overhead);
			for (int b = 0; b < beats; b++) begin
				for (int j = 0; j < pkt_gen_pkg::beat_bytes; j++) begin
					off = b * pkt_gen_pkg::beat_bytes + j;
					beat[pkt_gen_pkg::data_w-1-8*j -: 8] = off[7:0];  // byte 0 at msb
				end
				if (b == 0)
					beat[pkt_gen_pkg::data_w-1 -: 128] = {da, sa, pay_len, exp_index};
				exp_data.push_back(beat);
				exp_sop.push_back(b == 0);
				exp_eop.push_back(b == beats - 1);
				if (b == beats - 1)
					exp_empty.push_back(pkt_gen_pkg::empty_w'((beats * 64 - nbytes) % 64));
				else
					exp_empty.push_back('0);
			end
			exp_index = exp_index + 1'b1;
			if (mode == 1)
				len = (len >= hi) ? lo : len + 1;  // incr wraps at end_len
		end
	endtask

	// ----------------------------------------
	// stimulus helpers
	// ----------------------------------------
	task automatic next_cycle();
		@(negedge clk);
		if (stall_pct == 0)
			tx_ack_i = 1'b1;
		else
			tx_ack_i = ($urandom % 100) >= stall_pct;
	endtask

	task automatic wait_idle();
		int waited;

		waited = 0;
		while (busy_o || tx_valid_o) begin
			next_cycle();
			waited++;
			if (waited > wait_limit) begin
				$display("generator did not return to idle in time");
				stop_on_error();
			end
		end
	endtask

	// start pulse while a run is going, must be ignored
	task automatic start_while_busy();
		start_i = 1'b1;
		pkt_num_i = 32'd7;
		start_len_i = 14'd300;
		next_cycle();
		start_i = 1'b0;
	endtask

	task automatic run_one(input int mode, input int sl, input int el, input int n,
		input int stall, input int exp_pkts);
		int waited;
		int beat_cnt;
		int eop_cnt;
		logic [pkt_gen_pkg::mac_w-1:0] da;
		logic [pkt_gen_pkg::mac_w-1:0] sa;

		stall_pct = 0;
		wait_idle();
		got_data.delete();
		got_sop.delete();
		got_eop.delete();
		got_empty.delete();
		exp_data.delete();
		exp_sop.delete();
		exp_eop.delete();
		exp_empty.delete();
		da = pkt_gen_pkg::mac_w'({$urandom, $urandom});
		sa = pkt_gen_pkg::mac_w'({$urandom, $urandom});
		build_expected(mode, sl, el, n, da, sa);

		@(negedge clk);
		len_mode_i = pkt_gen_pkg::len_mode_t'(mode);
		start_len_i = pkt_gen_pkg::len_w'(sl);
		end_len_i = pkt_gen_pkg::len_w'(el);
		pkt_num_i = pkt_gen_pkg::cnt_w'(n);
		dest_addr_i = da;
		src_addr_i = sa;
		start_i = 1'b1;
		tx_ack_i = 1'b1;  // start must see an acked edge
		stall_pct = stall;
		next_cycle();
		start_i = 1'b0;

		if (n == 0) begin
			repeat (4) next_cycle();
			compare_flag("busy_o", busy_o, 1'b0);
			compare_flag("tx_valid_o", tx_valid_o, 1'b0);
		end else if (stall == 0) begin
			// exact latency and gapless stream
			compare_flag("busy_o", busy_o, 1'b0);
			compare_flag("tx_valid_o", tx_valid_o, 1'b0);
			next_cycle();
			compare_flag("busy_o", busy_o, 1'b1);
			compare_flag("tx_valid_o", tx_valid_o, 1'b0);
			next_cycle();
			compare_flag("tx_valid_o", tx_valid_o, 1'b1);
			beat_cnt = 1;
			start_while_busy();
			waited = 0;
			while (tx_valid_o) begin
				beat_cnt++;
				next_cycle();
				waited++;
				if (waited > wait_limit) begin
					$display("run did not end in time");
					stop_on_error();
				end
			end
			compare_count("gapless beat count", beat_cnt, exp_data.size());
			compare_flag("busy_o", busy_o, 1'b0);
		end else begin
			waited = 0;
			while (!busy_o) begin
				next_cycle();
				waited++;
				if (waited > wait_limit) begin
					$display("busy never rose after start");
					stop_on_error();
				end
			end
			start_while_busy();
			wait_idle();
		end

		// transferred stream vs model
		compare_count("beat count", got_data.size(), exp_data.size());
		eop_cnt = 0;
		foreach (got_data[i]) begin
			compare_data("tx_data_o", got_data[i], exp_data[i]);
			compare_flag("tx_sop_o", got_sop[i], exp_sop[i]);
			compare_flag("tx_eop_o", got_eop[i], exp_eop[i]);
			compare_empty("tx_empty_o", got_empty[i], exp_empty[i]);
			if (got_eop[i])
				eop_cnt++;
		end
		compare_count("packet count", eop_cnt, exp_pkts);
	endtask

	// ----------------------------------------
	// main
	// ----------------------------------------
	initial begin
		int fd;
		int fields;
		int runs_done;
		int mode;
		int sl;
		int el;
		int n;
		int stall;
		int exp_pkts;
		string line;

		void'($urandom(79305));
		clk = 1'b0;
		reset = 1'b1;
		start_i = 1'b0;
		len_mode_i = pkt_gen_pkg::mode_fixed;
		start_len_i = '0;
		end_len_i = '0;
		pkt_num_i = '0;
		dest_addr_i = '0;
		src_addr_i = '0;
		tx_ack_i = 1'b1;
		stall_pct = 0;
		exp_index = '0;
		runs_done = 0;

		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		fd = $fopen("pkt_gen_testdata.txt", "r");
		if (fd == 0) begin
			$display("cannot open the test data file");
			stop_on_error();
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() == 0 || line.getc(0) == 8'h23)
				continue;  // blank or comment
			fields = $sscanf(line, "%d %d %d %d %d %d", mode, sl, el, n, stall, exp_pkts);
			if (fields != 6)
				continue;
			run_one(mode, sl, el, n, stall, exp_pkts);
			runs_done++;
		end
		$fclose(fd);

		if (runs_done == 0) begin
			$display("no runs found in the test data file");
			stop_on_error();
		end else begin
			$display("Verification passed");
			$finish;
		end
	end

endmodule

// File: pkt_gen_testdata.txt
# columns: mode(0 fixed, 1 incr) start_len end_len pkt_num stall_pct expected_pkts
# lengths include the 4 crc bytes
0 64 64 3 0 3
0 68 68 3 0 3
0 69 69 3 0 3
0 132 132 2 0 2
0 133 133 2 0 2
0 1500 1500 2 0 2
1 64 70 10 0 10
1 100 100 4 0 4
0 20 20 2 0 2
0 12000 12000 2 0 2
1 9598 9700 5 0 5
1 30 66 6 0 6
0 100 100 0 0 0
0 133 133 5 30 5
1 64 200 20 50 20
0 69 69 8 70 8
1 120 125 9 25 9

// File: sources.f
pkt_gen_pkg.sv
pkt_gen_ctrl.sv
pkt_run_counter.sv
frame_length_seq.sv
beat_builder.sv
pkt_gen_tx.sv
pkt_gen_tx_checker.sv
tb_pkt_gen_tx.sv

// File: Makefile
# Verilator build of the pkt_gen_tx testbench; override any variable on the command line

VERILATOR ?= verilator
TOP       ?= tb_pkt_gen_tx
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
